// ==== rtl/pd_pkg.sv ====
package pd_pkg;

    // Block format
    localparam int WORD_W = 64;
    localparam int BYTES  = WORD_W / 8;

    localparam logic [1:0] HDR_DATA = 2'b01;
    localparam logic [1:0] HDR_CTRL = 2'b10;

    // Control type codes in bits 63:56 of a control block
    typedef enum logic [7:0] {
        TC_IDLE  = 8'h00,
        TC_S1    = 8'h1e,
        TC_S2    = 8'h2d,
        TC_S3    = 8'h33,
        TC_S4    = 8'h4b,
        TC_S5    = 8'h55,
        TC_T0    = 8'h66,
        TC_T1    = 8'h78,
        TC_T2    = 8'h87,
        TC_T3    = 8'h99,
        TC_T4    = 8'haa,
        TC_T5    = 8'hb4,
        TC_T6    = 8'hcc,
        TC_T7    = 8'hd2,
        TC_ERROR = 8'he1,
        TC_PAUSE = 8'hff
    } type_code_t;

    typedef enum logic [2:0] {
        BK_DATA,
        BK_START,
        BK_TERM,
        BK_IDLE,
        BK_PAUSE,
        BK_ERR,
        BK_BAD
    } block_kind_t;

    typedef enum logic [1:0] {
        ST_WAIT,
        ST_BODY,
        ST_TAIL
    } frame_state_t;

    typedef enum logic [2:0] {
        OP_NONE,
        OP_START,
        OP_JOIN,
        OP_TERM,
        OP_TAIL
    } beat_op_t;

endpackage

// ==== rtl/block_classifier.sv ====
`timescale 1ns/1ps

module block_classifier (
    input  logic                      clk_in,
    input  logic                      rst_in,
    input  logic [pd_pkg::WORD_W-1:0] payload_in,
    input  logic [1:0]                header_in,
    input  logic                      valid_in,
    output logic [pd_pkg::WORD_W-1:0] cur_word,
    output logic                      cur_valid,
    output pd_pkg::block_kind_t       cur_kind,
    output logic [2:0]                cur_count,
    output logic [pd_pkg::WORD_W-1:0] next_word,
    output pd_pkg::block_kind_t       next_kind,
    output logic [2:0]                next_count
);
    import pd_pkg::*;

    logic [1:0] cur_header;

    function automatic block_kind_t kind_of(logic [1:0] header, logic [WORD_W-1:0] word);
        if (header == HDR_DATA) begin
            return BK_DATA;
        end
        if (header != HDR_CTRL) begin
            return BK_ERR;
        end
        case (word[63:56])
            TC_S1, TC_S2, TC_S3, TC_S4, TC_S5: return BK_START;
            TC_T0, TC_T1, TC_T2, TC_T3,
            TC_T4, TC_T5, TC_T6, TC_T7:        return BK_TERM;
            TC_IDLE:                           return BK_IDLE;
            TC_PAUSE:                          return BK_PAUSE;
            TC_ERROR:                          return BK_ERR;
            default:                           return BK_BAD;
        endcase
    endfunction

    // Bytes carried by a start or terminate block, T0 falls to default
    function automatic logic [2:0] count_of(logic [WORD_W-1:0] word);
        case (word[63:56])
            TC_S1, TC_T1: return 3'd1;
            TC_S2, TC_T2: return 3'd2;
            TC_S3, TC_T3: return 3'd3;
            TC_S4, TC_T4: return 3'd4;
            TC_S5, TC_T5: return 3'd5;
            TC_T6:        return 3'd6;
            TC_T7:        return 3'd7;
            default:      return 3'd0;
        endcase
    endfunction

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            cur_valid <= 1'b0;
        end else begin
            cur_valid <= valid_in;
        end
    end

    always_ff @(posedge clk_in) begin
        cur_word   <= payload_in;
        cur_header <= header_in;
    end

    assign cur_kind  = kind_of(cur_header, cur_word);
    assign cur_count = count_of(cur_word);

    // An empty input slot looks like idle to the FSM
    assign next_word  = payload_in;
    assign next_kind  = valid_in ? kind_of(header_in, payload_in) : BK_IDLE;
    assign next_count = count_of(payload_in);

endmodule

// ==== rtl/frame_fsm.sv ====
`timescale 1ns/1ps

module frame_fsm (
    input  logic                clk_in,
    input  logic                rst_in,
    input  logic                cur_valid,
    input  pd_pkg::block_kind_t cur_kind,
    input  logic [2:0]          cur_count,
    input  pd_pkg::block_kind_t next_kind,
    input  logic [2:0]          next_count,
    output pd_pkg::beat_op_t    beat_op,
    output logic                m_error
);
    import pd_pkg::*;

    frame_state_t state_q;
    frame_state_t state_d;
    logic         lead;
    logic         err_d;
    // Current block was already used as look-ahead
    logic         skip_q;
    logic         skip_d;

    always_comb begin
        beat_op = OP_NONE;
        state_d = state_q;
        err_d   = 1'b0;
        skip_d  = 1'b0;
        lead    = 1'b0;

        case (state_q)
            ST_WAIT: begin
                if (cur_valid && !skip_q) begin
                    if (cur_kind == BK_START && cur_count != 3'd5) begin
                        beat_op = OP_START;
                    end else if (cur_kind == BK_START) begin
                        lead = 1'b1;
                    end else if (cur_kind != BK_IDLE && cur_kind != BK_PAUSE) begin
                        err_d = 1'b1;
                    end
                end
            end
            ST_BODY: begin
                lead = 1'b1;
            end
            ST_TAIL: begin
                beat_op = OP_TAIL;
                state_d = ST_WAIT;
            end
            default: begin
                state_d = ST_WAIT;
            end
        endcase

        // Five bytes of the current block wait for the look-ahead block
        if (lead) begin
            state_d = ST_WAIT;
            if (next_kind == BK_DATA) begin
                beat_op = OP_JOIN;
                state_d = ST_BODY;
            end else if (next_kind == BK_TERM) begin
                beat_op = OP_TERM;
                if (next_count > 3'd3) begin
                    state_d = ST_TAIL;
                end else begin
                    skip_d = 1'b1;
                end
            end else begin
                // Abort, a start block may still open the next frame
                err_d  = 1'b1;
                skip_d = (next_kind != BK_START);
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state_q <= ST_WAIT;
            skip_q  <= 1'b0;
            m_error <= 1'b0;
        end else begin
            state_q <= state_d;
            skip_q  <= skip_d;
            m_error <= err_d;
        end
    end

endmodule

// ==== rtl/lane_assembler.sv ====
`timescale 1ns/1ps

module lane_assembler (
    input  logic                      clk_in,
    input  logic                      rst_in,
    input  pd_pkg::beat_op_t          beat_op,
    input  logic [pd_pkg::WORD_W-1:0] cur_word,
    input  logic [2:0]                cur_count,
    input  logic [pd_pkg::WORD_W-1:0] next_word,
    input  logic [2:0]                next_count,
    output logic [pd_pkg::WORD_W-1:0] m_axis_tdata,
    output logic [pd_pkg::BYTES-1:0]  m_axis_tkeep,
    output logic [7:0]                m_axis_tuser,
    output logic [7:0]                m_axis_tdest,
    output logic                      m_axis_tlast,
    output logic                      m_axis_tvalid
);
    import pd_pkg::*;

    logic [WORD_W-1:0] raw;
    logic [WORD_W-1:0] data_d;
    logic [BYTES-1:0]  keep_d;
    logic [3:0]        nbytes;
    logic              last_d;
    logic              mid_frame_q;
    logic              take_ids;

    always_comb begin
        raw    = '0;
        nbytes = 4'd0;
        last_d = 1'b0;
        case (beat_op)
            OP_START: begin
                raw    = {cur_word[39:0], 24'h0};
                nbytes = {1'b0, cur_count};
                last_d = 1'b1;
            end
            OP_JOIN: begin
                raw    = {cur_word[39:0], next_word[63:40]};
                nbytes = 4'd8;
            end
            OP_TERM: begin
                // Up to three terminate bytes fit behind the five held ones
                raw    = {cur_word[39:0], next_word[55:32]};
                nbytes = (next_count > 3'd3) ? 4'd8 : 4'd5 + {1'b0, next_count};
                last_d = (next_count <= 3'd3);
            end
            OP_TAIL: begin
                raw    = {cur_word[31:0], 32'h0};
                nbytes = {1'b0, cur_count} - 4'd3;
                last_d = 1'b1;
            end
            default: begin
            end
        endcase

        keep_d = ~({BYTES{1'b1}} >> nbytes);
        for (int i = 0; i < BYTES; i++) begin
            data_d[i*8 +: 8] = keep_d[i] ? raw[i*8 +: 8] : 8'h00;
        end
    end

    // First beat of a frame has the start block as current block
    assign take_ids = (beat_op == OP_START) ||
                      ((beat_op == OP_JOIN || beat_op == OP_TERM) && !mid_frame_q);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            m_axis_tvalid <= 1'b0;
            mid_frame_q   <= 1'b0;
        end else begin
            m_axis_tvalid <= (beat_op != OP_NONE);
            mid_frame_q   <= (beat_op == OP_JOIN);
        end
    end

    always_ff @(posedge clk_in) begin
        m_axis_tdata <= data_d;
        m_axis_tkeep <= keep_d;
        m_axis_tlast <= last_d;
        if (take_ids) begin
            m_axis_tuser <= cur_word[55:48];
            m_axis_tdest <= cur_word[47:40];
        end
    end

endmodule

// ==== rtl/pause_decoder.sv ====
`timescale 1ns/1ps

module pause_decoder (
    input  logic                      clk_in,
    input  logic                      rst_in,
    input  logic                      cur_valid,
    input  pd_pkg::block_kind_t       cur_kind,
    input  logic [pd_pkg::WORD_W-1:0] cur_word,
    output logic                      pause_out,
    output logic                      unpause_out,
    output logic [7:0]                pause_src_out
);
    import pd_pkg::*;

    logic is_pause;
    logic all_ones;

    assign is_pause = cur_valid && (cur_kind == BK_PAUSE);
    // Full pause field means pause, anything else releases
    assign all_ones = &cur_word[39:8];

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            pause_out     <= 1'b0;
            unpause_out   <= 1'b0;
            pause_src_out <= 8'h00;
        end else begin
            pause_out     <= is_pause && all_ones;
            unpause_out   <= is_pause && !all_ones;
            pause_src_out <= is_pause ? cur_word[55:48] : 8'h00;
        end
    end

endmodule

// ==== rtl/payload_decoder.sv ====
`timescale 1ns/1ps

module payload_decoder (
    input  logic                      clk_in,
    input  logic                      rst_in,
    input  logic [pd_pkg::WORD_W-1:0] payload_in,
    input  logic [1:0]                header_in,
    input  logic                      valid_in,
    output logic [pd_pkg::WORD_W-1:0] m_axis_tdata,
    output logic [pd_pkg::BYTES-1:0]  m_axis_tkeep,
    output logic [7:0]                m_axis_tuser,
    output logic [7:0]                m_axis_tdest,
    output logic                      m_axis_tlast,
    output logic                      m_axis_tvalid,
    output logic                      m_error,
    output logic                      pause_out,
    output logic                      unpause_out,
    output logic [7:0]                pause_src_out
);
    import pd_pkg::*;

    logic [WORD_W-1:0] cur_word;
    logic              cur_valid;
    block_kind_t       cur_kind;
    logic [2:0]        cur_count;
    logic [WORD_W-1:0] next_word;
    block_kind_t       next_kind;
    logic [2:0]        next_count;
    beat_op_t          beat_op;

    block_classifier block_classifier_inst (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .payload_in (payload_in),
        .header_in  (header_in),
        .valid_in   (valid_in),
        .cur_word   (cur_word),
        .cur_valid  (cur_valid),
        .cur_kind   (cur_kind),
        .cur_count  (cur_count),
        .next_word  (next_word),
        .next_kind  (next_kind),
        .next_count (next_count)
    );

    frame_fsm frame_fsm_inst (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .cur_valid  (cur_valid),
        .cur_kind   (cur_kind),
        .cur_count  (cur_count),
        .next_kind  (next_kind),
        .next_count (next_count),
        .beat_op    (beat_op),
        .m_error    (m_error)
    );

    lane_assembler lane_assembler_inst (
        .clk_in        (clk_in),
        .rst_in        (rst_in),
        .beat_op       (beat_op),
        .cur_word      (cur_word),
        .cur_count     (cur_count),
        .next_word     (next_word),
        .next_count    (next_count),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tkeep  (m_axis_tkeep),
        .m_axis_tuser  (m_axis_tuser),
        .m_axis_tdest  (m_axis_tdest),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tvalid (m_axis_tvalid)
    );

    pause_decoder pause_decoder_inst (
        .clk_in        (clk_in),
        .rst_in        (rst_in),
        .cur_valid     (cur_valid),
        .cur_kind      (cur_kind),
        .cur_word      (cur_word),
        .pause_out     (pause_out),
        .unpause_out   (unpause_out),
        .pause_src_out (pause_src_out)
    );

endmodule

// ==== tests/payload_decoder_sva.sv ====
`timescale 1ns/1ps

module payload_decoder_sva (
    input logic       clk_in,
    input logic       rst_in,
    input logic       m_axis_tvalid,
    input logic [7:0] m_axis_tkeep,
    input logic       m_error,
    input logic       pause_out,
    input logic       unpause_out
);

    // Kept bytes packed toward the MSB
    keep_contiguous: assert property (@(posedge clk_in) disable iff (rst_in)
        m_axis_tvalid |-> (m_axis_tkeep != 8'h00) &&
                          (((~m_axis_tkeep) & ((~m_axis_tkeep) + 8'h01)) == 8'h00))
        else $error("tkeep is empty or has a gap");

    beat_or_error: assert property (@(posedge clk_in) disable iff (rst_in)
        !(m_axis_tvalid && m_error))
        else $error("tvalid and m_error high together");

    quiet_after_reset: assert property (@(posedge clk_in)
        $fell(rst_in) |-> !m_axis_tvalid && !m_error && !pause_out && !unpause_out)
        else $error("output pulse in the cycle after reset");

endmodule

bind payload_decoder payload_decoder_sva payload_decoder_sva_inst (
    .clk_in        (clk_in),
    .rst_in        (rst_in),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tkeep  (m_axis_tkeep),
    .m_error       (m_error),
    .pause_out     (pause_out),
    .unpause_out   (unpause_out)
);

// ==== include/pd_frame_model.svh ====
`ifndef PD_FRAME_MODEL_SVH
`define PD_FRAME_MODEL_SVH

typedef struct packed {
    logic [63:0] data;
    logic [7:0]  keep;
    logic [7:0]  user;
    logic [7:0]  dest;
    logic        last;
} pd_beat_t;

// Frame as {header, payload} blocks, short frames need no terminate
function automatic void pd_frame_blocks(input byte unsigned bytes[$], input logic [7:0] tuser,
                                        input logic [7:0] tdest, ref logic [65:0] blocks[$]);
    logic [7:0]  s_code [5];
    logic [7:0]  t_code [8];
    logic [63:0] word;
    int          n;
    int          pos;
    s_code = '{pd_pkg::TC_S1, pd_pkg::TC_S2, pd_pkg::TC_S3, pd_pkg::TC_S4, pd_pkg::TC_S5};
    t_code = '{pd_pkg::TC_T0, pd_pkg::TC_T1, pd_pkg::TC_T2, pd_pkg::TC_T3,
               pd_pkg::TC_T4, pd_pkg::TC_T5, pd_pkg::TC_T6, pd_pkg::TC_T7};
    n = (bytes.size() < 5) ? bytes.size() : 5;
    word = {s_code[n-1], tuser, tdest, 40'h0};
    for (int i = 0; i < n; i++) begin
        word[39 - 8*i -: 8] = bytes[i];
    end
    blocks.push_back({pd_pkg::HDR_CTRL, word});
    if (bytes.size() < 5) begin
        return;
    end
    pos = 5;
    while (bytes.size() - pos >= 8) begin
        for (int i = 0; i < 8; i++) begin
            word[63 - 8*i -: 8] = bytes[pos + i];
        end
        blocks.push_back({pd_pkg::HDR_DATA, word});
        pos += 8;
    end
    n = bytes.size() - pos;
    word = {t_code[n], 56'h0};
    for (int i = 0; i < n; i++) begin
        word[55 - 8*i -: 8] = bytes[pos + i];
    end
    blocks.push_back({pd_pkg::HDR_CTRL, word});
endfunction

// Expected beats, frame bytes packed eight at a time from the MSB
function automatic void pd_frame_beats(input byte unsigned bytes[$], input logic [7:0] tuser,
                                       input logic [7:0] tdest, ref pd_beat_t beats[$]);
    pd_beat_t beat;
    for (int pos = 0; pos < bytes.size(); pos += 8) begin
        beat = '{data: '0, keep: '0, user: tuser, dest: tdest, last: (pos + 8 >= bytes.size())};
        for (int i = 0; i < 8 && pos + i < bytes.size(); i++) begin
            beat.data[63 - 8*i -: 8] = bytes[pos + i];
            beat.keep[7 - i]         = 1'b1;
        end
        beats.push_back(beat);
    end
endfunction

// Pause control block, field of all ones requests a pause
function automatic logic [65:0] pd_pause_block(input logic [7:0] src, input logic [31:0] field);
    return {pd_pkg::HDR_CTRL, pd_pkg::TC_PAUSE, src, 8'h00, field, 8'h00};
endfunction

`endif

// ==== tests/tb_payload_decoder.sv ====
`timescale 1ns/1ps

module tb_payload_decoder;
    import pd_pkg::*;
    `include "pd_frame_model.svh"

    localparam int ITEMS        = 300;
    localparam int RESET_CYCLES = 16;

    logic        clk_in = 1'b0;
    logic        rst_in;
    logic [63:0] payload_in;
    logic [1:0]  header_in;
    logic        valid_in;
    logic [63:0] m_axis_tdata;
    logic [7:0]  m_axis_tkeep;
    logic [7:0]  m_axis_tuser;
    logic [7:0]  m_axis_tdest;
    logic        m_axis_tlast;
    logic        m_axis_tvalid;
    logic        m_error;
    logic        pause_out;
    logic        unpause_out;
    logic [7:0]  pause_src_out;

    // Stimulus as {valid, header, payload}
    logic [66:0] stim[$];
    pd_beat_t    exp_beats[$];
    // Pause events as {pause, source}
    logic [8:0]  exp_pause[$];
    int          exp_errors   = 0;
    int          seen_errors  = 0;
    int          mismatches   = 0;
    int          other_errors = 0;
    int          cycle_count  = 0;
    int          cycle_limit  = 0;

    payload_decoder payload_decoder_inst (
        .clk_in        (clk_in),
        .rst_in        (rst_in),
        .payload_in    (payload_in),
        .header_in     (header_in),
        .valid_in      (valid_in),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tkeep  (m_axis_tkeep),
        .m_axis_tuser  (m_axis_tuser),
        .m_axis_tdest  (m_axis_tdest),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tvalid (m_axis_tvalid),
        .m_error       (m_error),
        .pause_out     (pause_out),
        .unpause_out   (unpause_out),
        .pause_src_out (pause_src_out)
    );

    always #10 clk_in = ~clk_in;

    function automatic logic [65:0] control_block(input logic [7:0] code);
        return {HDR_CTRL, code, 56'h0};
    endfunction

    task automatic build_stimulus();
        byte unsigned bytes[$];
        byte unsigned head[$];
        logic [65:0]  blocks[$];
        pd_beat_t     beats[$];
        pd_beat_t     beat;
        logic [7:0]   tuser;
        logic [7:0]   tdest;
        logic [31:0]  field;
        int           kind;
        int           len;
        int           k;
        for (int item = 0; item < ITEMS; item++) begin
            bytes.delete();
            head.delete();
            blocks.delete();
            beats.delete();
            tuser = 8'($urandom);
            tdest = 8'($urandom);
            kind  = $urandom_range(7, 0);
            case (kind)
                0, 1, 2: begin
                    if (kind == 0) begin
                        len = $urandom_range(4, 1);
                    end else begin
                        len = 5 + 8 * $urandom_range(6, 0) + $urandom_range(7, 0);
                    end
                    repeat (len) bytes.push_back(8'($urandom));
                    pd_frame_blocks(bytes, tuser, tdest, blocks);
                    pd_frame_beats(bytes, tuser, tdest, exp_beats);
                end
                3: begin
                    repeat ($urandom_range(3, 1)) blocks.push_back(control_block(TC_IDLE));
                end
                4: begin
                    repeat ($urandom_range(3, 1)) begin
                        stim.push_back({1'b0, 2'($urandom), $urandom, $urandom});
                    end
                end
                5: begin
                    field = ($urandom_range(1, 0) == 1) ? 32'hffff_ffff : $urandom;
                    blocks.push_back(pd_pause_block(tuser, field));
                    exp_pause.push_back({field == 32'hffff_ffff, tuser});
                end
                6: begin
                    // Blocks that are illegal outside a frame
                    case ($urandom_range(3, 0))
                        0: blocks.push_back(control_block(TC_ERROR));
                        1: blocks.push_back(control_block(8'h5a));
                        2: blocks.push_back({2'b11, $urandom, $urandom});
                        default: blocks.push_back({HDR_DATA, $urandom, $urandom});
                    endcase
                    exp_errors++;
                end
                default: begin
                    // Long frame cut off by a control block where the terminate belongs
                    k = $urandom_range(4, 0);
                    repeat (5 + 8 * k) bytes.push_back(8'($urandom));
                    pd_frame_blocks(bytes, tuser, tdest, blocks);
                    void'(blocks.pop_back());
                    case ($urandom_range(2, 0))
                        0: blocks.push_back(control_block(TC_IDLE));
                        1: blocks.push_back(control_block(TC_ERROR));
                        default: blocks.push_back(control_block(8'h5a));
                    endcase
                    exp_errors++;
                    for (int i = 0; i < 8 * k; i++) begin
                        head.push_back(bytes[i]);
                    end
                    if (k > 0) begin
                        pd_frame_beats(head, tuser, tdest, beats);
                    end
                    foreach (beats[i]) begin
                        beat      = beats[i];
                        beat.last = 1'b0;
                        exp_beats.push_back(beat);
                    end
                end
            endcase
            foreach (blocks[i]) begin
                stim.push_back({1'b1, blocks[i]});
            end
        end
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] want);
        mismatches++;
        $display("Fail %s: got %h, expected %h", name, got, want);
    endtask

    task automatic check_outputs();
        pd_beat_t   exp;
        logic [8:0] ev;
        if (m_axis_tvalid && m_error) begin
            other_errors++;
            $display("A beat and an error pulse came out in the same cycle");
        end
        if (m_error) begin
            seen_errors++;
        end
        if (m_axis_tvalid) begin
            if (exp_beats.size() == 0) begin
                other_errors++;
                $display("Extra beat came out when no beat was expected");
            end else begin
                exp = exp_beats.pop_front();
                if (m_axis_tdata !== exp.data) begin
                    report_mismatch("m_axis_tdata", m_axis_tdata, exp.data);
                end
                if (m_axis_tkeep !== exp.keep) begin
                    report_mismatch("m_axis_tkeep", 64'(m_axis_tkeep), 64'(exp.keep));
                end
                if (m_axis_tuser !== exp.user) begin
                    report_mismatch("m_axis_tuser", 64'(m_axis_tuser), 64'(exp.user));
                end
                if (m_axis_tdest !== exp.dest) begin
                    report_mismatch("m_axis_tdest", 64'(m_axis_tdest), 64'(exp.dest));
                end
                if (m_axis_tlast !== exp.last) begin
                    report_mismatch("m_axis_tlast", 64'(m_axis_tlast), 64'(exp.last));
                end
            end
        end
        if (pause_out || unpause_out) begin
            if (exp_pause.size() == 0) begin
                other_errors++;
                $display("Pause pulse came out with no pause block sent");
            end else begin
                ev = exp_pause.pop_front();
                if (pause_out !== ev[8]) begin
                    report_mismatch("pause_out", 64'(pause_out), 64'(ev[8]));
                end
                if (unpause_out !== !ev[8]) begin
                    report_mismatch("unpause_out", 64'(unpause_out), 64'(!ev[8]));
                end
                if (pause_src_out !== ev[7:0]) begin
                    report_mismatch("pause_src_out", 64'(pause_src_out), 64'(ev[7:0]));
                end
            end
        end else if (pause_src_out !== 8'h00) begin
            report_mismatch("pause_src_out", 64'(pause_src_out), 64'h0);
        end
    endtask

    function automatic bit drained();
        return exp_beats.size() == 0 && exp_pause.size() == 0 && seen_errors >= exp_errors;
    endfunction

    always @(negedge clk_in) begin
        if (!rst_in) begin
            check_outputs();
        end
    end

    always @(posedge clk_in) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles with %0d beats and %0d pause events missing",
                     cycle_count, exp_beats.size(), exp_pause.size());
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'hd2e8_e3b2));
        rst_in     = 1'b1;
        valid_in   = 1'b0;
        header_in  = 2'b00;
        payload_in = '0;
        build_stimulus();
        cycle_limit = 4 * (stim.size() + RESET_CYCLES + 8);
        repeat (RESET_CYCLES) @(posedge clk_in);
        rst_in <= 1'b0;
        while (stim.size() > 0) begin
            @(posedge clk_in);
            {valid_in, header_in, payload_in} <= stim.pop_front();
        end
        @(posedge clk_in);
        valid_in <= 1'b0;
        while (!drained()) begin
            @(posedge clk_in);
        end
        // Room for any late extra beat or pulse
        repeat (4) @(posedge clk_in);
        if (seen_errors != exp_errors) begin
            other_errors++;
            $display("m_error pulsed %0d times, expected %0d", seen_errors, exp_errors);
        end
        $display("Errors: %0d value mismatches, %0d other failures", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+include
rtl/pd_pkg.sv
rtl/block_classifier.sv
rtl/frame_fsm.sv
rtl/lane_assembler.sv
rtl/pause_decoder.sv
rtl/payload_decoder.sv
tests/payload_decoder_sva.sv
tests/tb_payload_decoder.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module tb_payload_decoder -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "Verification passed" \
    || exit 1
